/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_usb_rx
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic tb_clk,
    output logic tb_n_rst
);

    // 8 ns period
    initial begin
        tb_clk = 1'b0;
        forever begin
            #4 tb_clk = ~tb_clk;
        end
    end

    // Released on a falling edge, clear of the flops' sampling edge
    initial begin
        tb_n_rst = 1'b0;
        repeat (10) @(posedge tb_clk);
        @(negedge tb_clk);
        tb_n_rst = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/tb_usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_usb_rx;

    typedef enum int {f_none, f_bad_pid, f_stuff, f_partial, f_overrun} fault_t;

    typedef struct packed {
        usb_rx_pkg::pid_t       pid;
        int                     nbytes;
        fault_t                 fault;
        usb_rx_pkg::rx_packet_t kind;
        bit                     heavy;
    } row_t;

    logic                   tb_clk;
    logic                   tb_n_rst;
    logic                   d_plus;
    logic                   d_minus;
    logic                   r_enable;
    usb_rx_pkg::byte_t      rx_packet_data;
    usb_rx_pkg::rx_packet_t rx_packet;
    logic                   store_rx_packet;
    logic                   r_error;
    logic                   packet_done;
    logic                   data_loaded;

    row_t              table_q[$];
    usb_rx_pkg::byte_t payload_q[$];
    usb_rx_pkg::byte_t got_q[$];
    logic              tx_bits[$];
    int                stuff_run;
    int                seed;
    int                wait_limit;
    int                error_count;
    int                tests_run;
    int                tests_ok;
    bit                timed_out;
    bit                line_done;

    tb_clock_gen clk_gen (.tb_clk, .tb_n_rst);

    usb_rx uut (
        .tb_clk, .tb_n_rst, .d_plus, .d_minus, .r_enable,
        .rx_packet_data, .rx_packet, .store_rx_packet,
        .r_error, .packet_done, .data_loaded
    );

    task automatic check_value(input int test, input string what, input int got,
                               input int expected);
        assert (got == expected) else begin
            $display("error at %0t: test %0d %s is %0h, expected %0h",
                     $time, test, what, got, expected);
            error_count++;
        end
    endtask

    task automatic add_row(input usb_rx_pkg::pid_t pid, input int nbytes, input fault_t fault,
                           input usb_rx_pkg::rx_packet_t kind, input bit heavy);
        row_t r;
        r.pid = pid;
        r.nbytes = nbytes;
        r.fault = fault;
        r.kind = kind;
        r.heavy = heavy;
        table_q.push_back(r);
    endtask

    task automatic load_table();
        add_row(usb_rx_pkg::pid_out, 0, f_none, usb_rx_pkg::pkt_out, 0);
        add_row(usb_rx_pkg::pid_in, 0, f_none, usb_rx_pkg::pkt_in, 0);
        add_row(usb_rx_pkg::pid_setup, 0, f_none, usb_rx_pkg::pkt_setup, 0);
        add_row(usb_rx_pkg::pid_ack, 0, f_none, usb_rx_pkg::pkt_ack, 0);
        add_row(usb_rx_pkg::pid_nak, 0, f_none, usb_rx_pkg::pkt_nak, 0);
        add_row(usb_rx_pkg::pid_data0, 4, f_none, usb_rx_pkg::pkt_data0, 0);
        add_row(usb_rx_pkg::pid_data1, 3, f_none, usb_rx_pkg::pkt_data1, 0);
        // All-ones payloads force stuffed zeros
        add_row(usb_rx_pkg::pid_data0, 2, f_none, usb_rx_pkg::pkt_data0, 1);
        add_row(usb_rx_pkg::pid_data1, 4, f_none, usb_rx_pkg::pkt_data1, 1);
        add_row(8'h11, 2, f_bad_pid, usb_rx_pkg::pkt_none, 0);
        add_row(usb_rx_pkg::pid_data0, 1, f_none, usb_rx_pkg::pkt_data0, 0);
        add_row(usb_rx_pkg::pid_data1, 1, f_stuff, usb_rx_pkg::pkt_data1, 0);
        add_row(usb_rx_pkg::pid_data0, 2, f_none, usb_rx_pkg::pkt_data0, 0);
        add_row(usb_rx_pkg::pid_data0, 1, f_partial, usb_rx_pkg::pkt_data0, 0);
        add_row(usb_rx_pkg::pid_out, 0, f_none, usb_rx_pkg::pkt_out, 0);
        add_row(usb_rx_pkg::pid_data1, 3, f_overrun, usb_rx_pkg::pkt_data1, 0);
        add_row(usb_rx_pkg::pid_data0, 2, f_none, usb_rx_pkg::pkt_data0, 0);
    endtask

    task automatic push_data_bit(input logic b);
        tx_bits.push_back(b);
        stuff_run = b ? stuff_run + 1 : 0;
        if (stuff_run == usb_rx_pkg::stuff_limit) begin
            tx_bits.push_back(1'b0);
            stuff_run = 0;
        end
    endtask

    task automatic push_byte(input usb_rx_pkg::byte_t b);
        int i;
        for (i = 0; i < 8; i++) begin
            push_data_bit(b[i]);
        end
    endtask

    // Decoded bit stream of one packet sent LSB first and stuffed from SYNC on
    task automatic build_packet(input row_t r);
        int i;
        tx_bits.delete();
        stuff_run = 0;
        push_byte(usb_rx_pkg::sync_pattern);
        push_byte(r.pid);
        for (i = 0; i < payload_q.size(); i++) begin
            push_byte(payload_q[i]);
        end
        if (r.fault == f_stuff) begin
            // Seven raw ones with no stuffed zero among them
            for (i = 0; i < 7; i++) begin
                tx_bits.push_back(1'b1);
            end
        end else if (r.fault == f_partial) begin
            for (i = 0; i < 4; i++) begin
                push_data_bit(i[0]);
            end
        end
    endtask

    task automatic drive_line();
        logic level;
        int   i;
        level = 1'b1;
        for (i = 0; i < tx_bits.size(); i++) begin
            // NRZI where a zero toggles the line
            if (!tx_bits[i]) level = !level;
            d_plus = level;
            d_minus = !level;
            repeat (usb_rx_pkg::clocks_per_bit) @(negedge tb_clk);
        end
        d_plus = 1'b0;
        d_minus = 1'b0;
        repeat (2 * usb_rx_pkg::clocks_per_bit) @(negedge tb_clk);
        d_plus = 1'b1;
        d_minus = 1'b0;
        repeat (4 * usb_rx_pkg::clocks_per_bit) @(negedge tb_clk);
        line_done = 1'b1;
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        repeat (20) @(negedge tb_clk);
        check_value(0, "store_rx_packet", store_rx_packet, 0);
        check_value(0, "packet_done", packet_done, 0);
        check_value(0, "data_loaded", data_loaded, 0);
        check_value(0, "r_error", r_error, 0);
        check_value(0, "rx_packet", rx_packet, usb_rx_pkg::pkt_none);
        check_value(0, "rx_packet_data", rx_packet_data, 0);
        tests_run++;
        if (error_count == errors_before) tests_ok++;
        $display("test 0 reset: %s", (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    task automatic run_packet(input int test, input row_t r);
        usb_rx_pkg::byte_t      exp_q[$];
        usb_rx_pkg::rx_packet_t kind_at_done;
        usb_rx_pkg::byte_t      data_at_done;
        logic                   err_at_done;
        logic                   err_early;
        logic                   loaded_at_done;
        logic                   err_prev;
        int                     err_rises;
        int                     done_count;
        int                     cycles;
        int                     errors_before;
        int                     rnd;
        int                     i;
        errors_before = error_count;
        payload_q.delete();
        got_q.delete();
        for (i = 0; i < r.nbytes; i++) begin
            rnd = $random(seed);
            payload_q.push_back(r.heavy ? 8'hff : rnd[7:0]);
        end
        // A bad PID drops the whole packet and an overrun keeps only the first byte
        if (r.fault == f_overrun) begin
            exp_q.push_back(payload_q[0]);
        end else if (r.fault != f_bad_pid) begin
            exp_q = payload_q;
        end
        build_packet(r);
        line_done = 1'b0;
        done_count = 0;
        err_rises = 0;
        cycles = 0;
        err_prev = r_error;
        kind_at_done = usb_rx_pkg::pkt_none;
        data_at_done = '0;
        err_at_done = 1'b0;
        err_early = 1'b0;
        loaded_at_done = 1'b0;
        @(negedge tb_clk);
        fork
            drive_line();
            begin
                while (!(line_done && done_count > 0) && cycles < wait_limit) begin
                    @(negedge tb_clk);
                    cycles++;
                    r_enable = 1'b0;
                    if (store_rx_packet) begin
                        got_q.push_back(rx_packet_data);
                        r_enable = (r.fault != f_overrun);
                    end
                    if (packet_done) begin
                        if (done_count == 0) begin
                            kind_at_done = rx_packet;
                            data_at_done = rx_packet_data;
                            err_at_done = r_error;
                            // Level one cycle before the end of packet
                            err_early = err_prev;
                            loaded_at_done = data_loaded;
                        end
                        done_count++;
                    end
                    if (r_error && !err_prev) err_rises++;
                    err_prev = r_error;
                end
            end
        join
        r_enable = 1'b0;
        tests_run++;
        if (done_count == 0) begin
            $display("timeout: no packet_done within %0d cycles in test %0d", wait_limit, test);
            error_count++;
            timed_out = 1'b1;
            return;
        end
        check_value(test, "packet_done pulses", done_count, 1);
        check_value(test, "rx_packet", kind_at_done, r.kind);
        check_value(test, "bytes stored", got_q.size(), exp_q.size());
        for (i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value(test, $sformatf("byte %0d", i), got_q[i], exp_q[i]);
        end
        check_value(test, "r_error at packet_done", err_at_done, r.fault != f_none);
        // Only a partial byte waits for SE0 to raise the error
        check_value(test, "r_error before packet_done", err_early,
                    r.fault == f_bad_pid || r.fault == f_stuff || r.fault == f_overrun);
        if (r.fault == f_none) check_value(test, "r_error rises", err_rises, 0);
        check_value(test, "data_loaded at packet_done", loaded_at_done, r.fault == f_overrun);
        if (r.fault == f_overrun) begin
            check_value(test, "rx_packet_data after overrun", data_at_done, exp_q[0]);
            // Consumer finally reads the held byte
            r_enable = 1'b1;
            @(negedge tb_clk);
            r_enable = 1'b0;
            check_value(test, "data_loaded after read", data_loaded, 0);
        end
        if (error_count == errors_before) tests_ok++;
        $display("test %0d pid %h bytes %0d %s: %s", test, r.pid, r.nbytes, r.fault.name(),
                 (error_count == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int i;
        int cycles;
        d_plus = 1'b1;
        d_minus = 1'b0;
        r_enable = 1'b0;
        seed = 69;
        wait_limit = 2000;
        error_count = 0;
        tests_run = 0;
        tests_ok = 0;
        timed_out = 1'b0;
        line_done = 1'b0;
        load_table();
        cycles = 0;
        while (tb_n_rst !== 1'b1 && cycles < 100) begin
            @(negedge tb_clk);
            cycles++;
        end
        if (tb_n_rst !== 1'b1) begin
            $display("timeout: reset was never released");
            error_count++;
        end else begin
            check_reset_state();
            for (i = 0; i < table_q.size() && !timed_out; i++) begin
                run_packet(i + 1, table_q[i]);
            end
        end
        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/usb_bit_unstuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_bit_unstuffer (
    input  wire logic tb_clk,
    input  wire logic tb_n_rst,
    input  wire logic bit_strobe,
    input  wire logic bit_value,
    input  wire logic se0_strobe,
    output logic      data_strobe,
    output logic      data_bit,
    output logic      stuff_error
);

    logic [$clog2(usb_rx_pkg::stuff_limit + 1)-1:0] ones;

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            ones <= '0;
            data_strobe <= 1'b0;
            data_bit <= 1'b0;
            stuff_error <= 1'b0;
        end else begin
            data_strobe <= 1'b0;
            stuff_error <= 1'b0;
            if (se0_strobe) begin
                ones <= '0;
            end else if (bit_strobe) begin
                if (ones == usb_rx_pkg::stuff_limit) begin
                    // Stuffed slot, a one here breaks the rule
                    stuff_error <= bit_value;
                    ones <= '0;
                end else begin
                    data_strobe <= 1'b1;
                    data_bit <= bit_value;
                    ones <= bit_value ? ones + 1'b1 : '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/usb_byte_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_byte_assembler (
    input  wire logic          tb_clk,
    input  wire logic          tb_n_rst,
    input  wire logic          data_strobe,
    input  wire logic          data_bit,
    input  wire logic          align,
    output logic               byte_strobe,
    output usb_rx_pkg::byte_t  byte_data,
    output logic               sync_seen
);

    usb_rx_pkg::byte_t      shift_reg;
    usb_rx_pkg::byte_t      shift_next;
    usb_rx_pkg::bit_index_t bit_index;

    // LSB first, newest bit enters at the top
    assign shift_next = {data_bit, shift_reg[7:1]};

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            shift_reg <= '0;
            bit_index <= '0;
            byte_strobe <= 1'b0;
            byte_data <= '0;
            sync_seen <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            sync_seen <= 1'b0;
            if (align) begin
                bit_index <= '0;
            end else if (data_strobe) begin
                shift_reg <= shift_next;
                bit_index <= bit_index + 1'b1;
                sync_seen <= (shift_next == usb_rx_pkg::sync_pattern);
                if (bit_index == 3'd7) begin
                    byte_strobe <= 1'b1;
                    byte_data <= shift_next;
                end
            end
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst) !(byte_strobe && align));

endmodule

`default_nettype wire

/* hw/usb_line_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_line_sampler (
    input  wire logic tb_clk,
    input  wire logic tb_n_rst,
    input  wire logic d_plus,
    input  wire logic d_minus,
    output logic      bit_strobe,
    output logic      bit_value,
    output logic      se0_strobe
);

    logic [1:0] dp_sync;
    logic [1:0] dm_sync;
    logic       dp_last;
    logic       dm_last;
    logic [$clog2(usb_rx_pkg::clocks_per_bit)-1:0] phase;
    logic       active;
    logic       prev_dp;
    logic       prev_se0;
    logic       line_se0;
    logic       jk_edge;
    logic       sample;

    assign line_se0 = !dp_sync[1] && !dm_sync[1];

    // Only J<->K changes retime the bit clock, SE0 edges do not
    assign jk_edge = (dp_sync[1] != dp_last) && (dp_sync[1] != dm_sync[1])
                   && (dp_last != dm_last);
    assign sample = (phase == usb_rx_pkg::sample_offset);

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_sync <= 2'b11;
            dm_sync <= 2'b00;
            dp_last <= 1'b1;
            dm_last <= 1'b0;
            phase <= '0;
            active <= 1'b0;
            prev_dp <= 1'b1;
            prev_se0 <= 1'b0;
            bit_strobe <= 1'b0;
            bit_value <= 1'b0;
            se0_strobe <= 1'b0;
        end else begin
            dp_sync <= {dp_sync[0], d_plus};
            dm_sync <= {dm_sync[0], d_minus};
            dp_last <= dp_sync[1];
            dm_last <= dm_sync[1];
            bit_strobe <= 1'b0;
            se0_strobe <= 1'b0;
            if (jk_edge) begin
                phase <= '0;
                active <= 1'b1;
            end else if (phase == usb_rx_pkg::clocks_per_bit - 1) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
            if (sample) begin
                prev_se0 <= line_se0;
                if (line_se0) begin
                    se0_strobe <= prev_se0;
                    active <= 1'b0;
                    // Line returns to J after end of packet
                    prev_dp <= 1'b1;
                end else if (active) begin
                    bit_strobe <= 1'b1;
                    bit_value <= (dp_sync[1] == prev_dp);
                    prev_dp <= dp_sync[1];
                end
            end
        end
    end

    assert property (@(posedge tb_clk) disable iff (!tb_n_rst) !(bit_strobe && se0_strobe));

endmodule

`default_nettype wire

/* hw/usb_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx (
    input  wire logic               tb_clk,
    input  wire logic               tb_n_rst,
    input  wire logic               d_plus,
    input  wire logic               d_minus,
    input  wire logic               r_enable,
    output usb_rx_pkg::byte_t       rx_packet_data,
    output usb_rx_pkg::rx_packet_t  rx_packet,
    output logic                    store_rx_packet,
    output logic                    r_error,
    output logic                    packet_done,
    output logic                    data_loaded
);

    logic              bit_strobe;
    logic              bit_value;
    logic              se0_strobe;
    logic              data_strobe;
    logic              data_bit;
    logic              stuff_error;
    logic              byte_strobe;
    usb_rx_pkg::byte_t byte_data;
    logic              sync_seen;
    logic              align;

    usb_line_sampler u_sampler (
        .tb_clk, .tb_n_rst, .d_plus, .d_minus,
        .bit_strobe, .bit_value, .se0_strobe
    );

    usb_bit_unstuffer u_unstuffer (
        .tb_clk, .tb_n_rst, .bit_strobe, .bit_value, .se0_strobe,
        .data_strobe, .data_bit, .stuff_error
    );

    usb_byte_assembler u_assembler (
        .tb_clk, .tb_n_rst, .data_strobe, .data_bit, .align,
        .byte_strobe, .byte_data, .sync_seen
    );

    usb_rx_control u_control (
        .tb_clk, .tb_n_rst, .sync_seen, .byte_strobe, .byte_data,
        .se0_strobe, .stuff_error, .r_enable, .align,
        .rx_packet, .rx_packet_data, .store_rx_packet,
        .data_loaded, .r_error, .packet_done
    );

endmodule

`default_nettype wire

/* hw/usb_rx_control.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_rx_control (
    input  wire logic                tb_clk,
    input  wire logic                tb_n_rst,
    input  wire logic                sync_seen,
    input  wire logic                byte_strobe,
    input  wire usb_rx_pkg::byte_t   byte_data,
    input  wire logic                se0_strobe,
    input  wire logic                stuff_error,
    input  wire logic                r_enable,
    output logic                     align,
    output usb_rx_pkg::rx_packet_t   rx_packet,
    output usb_rx_pkg::byte_t        rx_packet_data,
    output logic                     store_rx_packet,
    output logic                     data_loaded,
    output logic                     r_error,
    output logic                     packet_done
);

    usb_rx_pkg::rx_state_t  state;
    usb_rx_pkg::rx_packet_t pid_kind;
    logic [2:0]             ones_run;
    logic [5:0]             gap_cnt;
    logic                   pid_ok;
    logic                   stuff_pending;
    logic                   partial;
    logic                   overrun;

    // Mirrors the unstuffer's ones count over the delivered bytes
    function automatic logic [2:0] ones_after(input logic [2:0] run_in,
                                              input usb_rx_pkg::byte_t b);
        logic [2:0] run;
        int i;
        run = run_in;
        for (i = 0; i < 8; i++) begin
            if (run == usb_rx_pkg::stuff_limit) run = '0;
            run = b[i] ? run + 1'b1 : 3'd0;
        end
        return run;
    endfunction

    always_comb begin
        case (byte_data)
            usb_rx_pkg::pid_out:   pid_kind = usb_rx_pkg::pkt_out;
            usb_rx_pkg::pid_in:    pid_kind = usb_rx_pkg::pkt_in;
            usb_rx_pkg::pid_setup: pid_kind = usb_rx_pkg::pkt_setup;
            usb_rx_pkg::pid_data0: pid_kind = usb_rx_pkg::pkt_data0;
            usb_rx_pkg::pid_data1: pid_kind = usb_rx_pkg::pkt_data1;
            usb_rx_pkg::pid_ack:   pid_kind = usb_rx_pkg::pkt_ack;
            usb_rx_pkg::pid_nak:   pid_kind = usb_rx_pkg::pkt_nak;
            default:               pid_kind = usb_rx_pkg::pkt_none;
        endcase
    end

    assign pid_ok = (byte_data[7:4] == ~byte_data[3:0]) && (pid_kind != usb_rx_pkg::pkt_none);
    assign stuff_pending = (ones_run == usb_rx_pkg::stuff_limit);
    // A whole byte leaves two bit times of SE0 and one more if a stuffed zero trails
    assign partial = gap_cnt > (2 * usb_rx_pkg::clocks_per_bit + usb_rx_pkg::clocks_per_bit / 2
                     + (stuff_pending ? usb_rx_pkg::clocks_per_bit : 0));
    assign overrun = byte_strobe && (state == usb_rx_pkg::st_data) && data_loaded;

    always_ff @(posedge tb_clk, negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state <= usb_rx_pkg::st_idle;
            align <= 1'b0;
            rx_packet <= usb_rx_pkg::pkt_none;
            rx_packet_data <= '0;
            store_rx_packet <= 1'b0;
            data_loaded <= 1'b0;
            r_error <= 1'b0;
            packet_done <= 1'b0;
            ones_run <= '0;
            gap_cnt <= '0;
        end else begin
            align <= 1'b0;
            store_rx_packet <= 1'b0;
            packet_done <= 1'b0;
            if (gap_cnt != '1) gap_cnt <= gap_cnt + 1'b1;
            if (r_enable && data_loaded) data_loaded <= 1'b0;
            case (state)
                usb_rx_pkg::st_idle: begin
                    if (sync_seen) begin
                        align <= 1'b1;
                        r_error <= 1'b0;
                        rx_packet <= usb_rx_pkg::pkt_none;
                        // SYNC ends in a one
                        ones_run <= 3'd1;
                        gap_cnt <= '0;
                        state <= usb_rx_pkg::st_pid;
                    end
                end
                usb_rx_pkg::st_pid, usb_rx_pkg::st_data: begin
                    if (se0_strobe) begin
                        packet_done <= 1'b1;
                        if (partial) r_error <= 1'b1;
                        state <= usb_rx_pkg::st_eop;
                    end else if (stuff_error) begin
                        r_error <= 1'b1;
                        state <= usb_rx_pkg::st_error;
                    end else if (byte_strobe) begin
                        gap_cnt <= '0;
                        ones_run <= ones_after(ones_run, byte_data);
                        if (state == usb_rx_pkg::st_pid) begin
                            if (pid_ok) begin
                                rx_packet <= pid_kind;
                                state <= usb_rx_pkg::st_data;
                            end else begin
                                r_error <= 1'b1;
                                state <= usb_rx_pkg::st_error;
                            end
                        end else if (overrun) begin
                            r_error <= 1'b1;
                        end else begin
                            rx_packet_data <= byte_data;
                            store_rx_packet <= 1'b1;
                            data_loaded <= 1'b1;
                        end
                    end
                end
                usb_rx_pkg::st_error: begin
                    if (se0_strobe) begin
                        packet_done <= 1'b1;
                        state <= usb_rx_pkg::st_eop;
                    end
                end
                default: state <= usb_rx_pkg::st_idle;
            endcase
        end
    end

    // An unread byte is never replaced or stored over
    assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        data_loaded && !r_enable |=> !store_rx_packet && $stable(rx_packet_data));
    assert property (@(posedge tb_clk) disable iff (!tb_n_rst) packet_done |=> !packet_done);

endmodule

`default_nettype wire

/* hw/usb_rx_pkg.sv */
`default_nettype none

package usb_rx_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [2:0] bit_index_t;
    typedef logic [7:0] pid_t;

    // Line timing, in receive clocks
    localparam int clocks_per_bit = 8;
    localparam int sample_offset = 3;
    localparam int stuff_limit = 6;

    // Seven zeros then a one, shifted in LSB first
    localparam byte_t sync_pattern = 8'h80;

    // PID byte as received, check nibble in the upper half
    localparam pid_t pid_out = 8'he1;
    localparam pid_t pid_in = 8'h69;
    localparam pid_t pid_setup = 8'h2d;
    localparam pid_t pid_data0 = 8'hc3;
    localparam pid_t pid_data1 = 8'h4b;
    localparam pid_t pid_ack = 8'hd2;
    localparam pid_t pid_nak = 8'h5a;

    typedef enum logic [2:0] {
        pkt_none, pkt_out, pkt_in, pkt_setup, pkt_data0, pkt_data1, pkt_ack, pkt_nak
    } rx_packet_t;

    typedef enum logic [2:0] {
        st_idle, st_pid, st_data, st_eop, st_error
    } rx_state_t;

endpackage

`default_nettype wire

/* list.f */
hw/usb_rx_pkg.sv
hw/usb_line_sampler.sv
hw/usb_bit_unstuffer.sv
hw/usb_byte_assembler.sv
hw/usb_rx_control.sv
hw/usb_rx.sv
dv/tb_clock_gen.sv
dv/tb_usb_rx.sv
